/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module icache_tb -o icache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* src.f */
+incdir+src
src/icache_pkg.sv
src/sdp_mem.sv
src/icache_lookup.sv
src/icache_hit_check.sv
src/icache_refill.sv
src/icache_top.sv
tests/tb_clock_gen.sv
tests/icache_assert.sv
tests/icache_tb.sv

/* src/icache_hit_check.sv */
// Cache stage 2: hit decision, word select and miss handling.
// On a miss the CPU port stalls, a line fetch starts, and the refill
// cycle writes the victim way and acks with the requested word.

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_hit_check (
    input  logic                               clk_i,
    input  logic                               rstn_i,

    input  logic                               req_valid_i,
    input  icache_pkg::fetch_addr_u            req_addr_i,
    input  logic [1:0]                         way_valid_i,
    input  logic [1:0][`ICACHE_TAG_W-1:0]      way_tag_i,
    input  icache_pkg::line_t [1:0]            way_line_i,
    input  logic                               line_ready_i,
    input  icache_pkg::line_t                  refill_line_i,

    output logic                               cpu_ack_o,
    output logic [`ICACHE_DATA_W-1:0]          cpu_dat_o,
    output logic                               cpu_stall_o,

    output logic                               fetch_start_o,

    output logic [1:0]                         valid_we_o,
    output logic [`ICACHE_SETS_LOG2-1:0]       wr_index_o,
    output logic [`ICACHE_TAG_W-1:0]           wr_tag_o,
    output icache_pkg::line_t                  wr_line_o
);

    import icache_pkg::*;

    localparam int unsigned NUM_SETS = 1 << `ICACHE_SETS_LOG2;

    enum logic [1:0] {RUNNING, WAIT_MEMORY, REFILL} state_q, state_d;

    logic [1:0]          match;     // per-way tag hit
    logic                hit;
    logic                miss;
    way_t                hit_way;
    way_t                victim;
    logic [NUM_SETS-1:0] age_q;     // points at the next way to replace

    // hit decision
    // **************************************************
    for (genvar w = 0; w < 2; w++) begin : g_match
        assign match[w] = way_valid_i[w] & (way_tag_i[w] == req_addr_i.fields.tag);
    end

    // lowest matching way wins
    always_comb begin
        hit_way = way_t'(1'b0);
        for (int w = 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit  = req_valid_i & (|match);
    assign miss = req_valid_i & ~(|match) & (state_q == RUNNING);

    assign victim = age_q[req_addr_i.fields.index];

    // miss / refill FSM
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= RUNNING;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RUNNING: begin
                if (miss) begin
                    state_d = WAIT_MEMORY;
                end
            end
            WAIT_MEMORY: begin
                if (line_ready_i) begin
                    state_d = REFILL;  // line captured on this edge
                end
            end
            REFILL: begin
                state_d = RUNNING;
            end
            default: begin
                state_d = RUNNING;
            end
        endcase
    end

    // age bits flip to the other way after each refill
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            age_q <= '0;
        end else if (state_q == REFILL) begin
            age_q[req_addr_i.fields.index] <= ~victim;
        end
    end

    // CPU port, early restart in REFILL
    assign cpu_stall_o   = (state_q != RUNNING) | miss;
    assign cpu_ack_o     = (state_q == REFILL) | ((state_q == RUNNING) & hit);
    assign cpu_dat_o     = (state_q == REFILL) ? refill_line_i[req_addr_i.fields.offset]
                                               : way_line_i[hit_way][req_addr_i.fields.offset];
    assign fetch_start_o = miss;  // one cycle, FSM leaves RUNNING

    // store writes go to the victim way
    always_comb begin
        valid_we_o         = '0;
        valid_we_o[victim] = (state_q == REFILL);
    end

    assign wr_index_o = req_addr_i.fields.index;
    assign wr_tag_o   = req_addr_i.fields.tag;
    assign wr_line_o  = refill_line_i;

endmodule

/* src/icache_lookup.sv */
// Cache stage 1: accepts CPU fetch requests and reads both ways.
// Tag, line and valid bits come out one cycle after acceptance,
// together with the registered request address.

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_lookup (
    input  logic                               clk_i,
    input  logic                               rstn_i,

    input  logic                               cpu_cyc_i,
    input  logic                               cpu_stb_i,
    input  logic [`ICACHE_ADDR_W-1:0]          cpu_adr_i,
    input  logic                               stall_i,

    input  logic [1:0]                         valid_we_i,
    input  logic [`ICACHE_SETS_LOG2-1:0]       wr_index_i,
    input  logic [`ICACHE_TAG_W-1:0]           wr_tag_i,
    input  icache_pkg::line_t                  wr_line_i,

    output logic                               req_valid_o,
    output icache_pkg::fetch_addr_u            req_addr_o,
    output logic [1:0]                         way_valid_o,
    output logic [1:0][`ICACHE_TAG_W-1:0]      way_tag_o,
    output icache_pkg::line_t [1:0]            way_line_o
);

    import icache_pkg::*;

    localparam int unsigned NUM_SETS = 1 << `ICACHE_SETS_LOG2;

    fetch_addr_u                  cpu_addr;   // incoming address, decoded
    logic                         accept;
    logic                         req_valid_q;
    fetch_addr_u                  req_addr_q;
    logic [1:0][NUM_SETS-1:0]     valid_q;    // one valid bit per way and set
    logic [1:0]                   valid_rd_q;

    assign cpu_addr.raw = cpu_adr_i;
    assign accept       = cpu_cyc_i & cpu_stb_i & ~stall_i;

    // request registers
    // **************************************************
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= accept;  // decided next cycle
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q <= cpu_addr;
        end
    end

    // valid bits, cleared by reset and set on refill
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q    <= '0;
            valid_rd_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (accept) begin
                    valid_rd_q[w] <= valid_q[w][cpu_addr.fields.index];
                end
                if (valid_we_i[w]) begin
                    valid_q[w][wr_index_i] <= 1'b1;
                end
            end
        end
    end

    // tag and data stores
    // **************************************************
    for (genvar w = 0; w < 2; w++) begin : g_way
        sdp_mem #(.DW(`ICACHE_TAG_W), .AW(`ICACHE_SETS_LOG2)) tag_mem_i (
            .clk_i     (clk_i),
            .rd_en_i   (accept),
            .rd_addr_i (cpu_addr.fields.index),
            .rd_data_o (way_tag_o[w]),
            .wr_en_i   (valid_we_i[w]),
            .wr_addr_i (wr_index_i),
            .wr_data_i (wr_tag_i)
        );

        sdp_mem #(.DW(`ICACHE_LINE_W), .AW(`ICACHE_SETS_LOG2)) data_mem_i (
            .clk_i     (clk_i),
            .rd_en_i   (accept),
            .rd_addr_i (cpu_addr.fields.index),
            .rd_data_o (way_line_o[w]),
            .wr_en_i   (valid_we_i[w]),
            .wr_addr_i (wr_index_i),
            .wr_data_i (wr_line_i)
        );
    end

    assign req_valid_o = req_valid_q;
    assign req_addr_o  = req_addr_q;
    assign way_valid_o = valid_rd_q;

endmodule

/* src/icache_pkg.sv */
// Types shared by the instruction cache stages.
// Compile before any cache module; modules import it inside their bodies.

`include "icache_settings.svh"

package icache_pkg;

    // word address split as the cache sees it
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]     tag;
        logic [`ICACHE_SETS_LOG2-1:0] index;
        logic [`ICACHE_OFFSET_W-1:0]  offset;
    } fetch_fields_t;

    // one fetch address, flat or decoded
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        fetch_fields_t             fields;
    } fetch_addr_u;

    // a cache line, word 0 in the low bits
    typedef logic [(1 << `ICACHE_OFFSET_W)-1:0][`ICACHE_DATA_W-1:0] line_t;

    // one of the two ways
    typedef logic way_t;

endpackage

/* src/icache_refill.sv */
// Memory-side Wishbone master of the instruction cache.
// Issues one 128-bit line read per fetch_start and holds the line.

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_refill (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,

    input  logic                                        fetch_start_i,
    input  icache_pkg::fetch_addr_u                     fetch_addr_i,

    input  logic                                        mem_stall_i,
    input  logic                                        mem_ack_i,
    input  logic [`ICACHE_LINE_W-1:0]                   mem_dat_i,
    output logic                                        mem_cyc_o,
    output logic                                        mem_stb_o,
    output logic [`ICACHE_ADDR_W-`ICACHE_OFFSET_W-1:0]  mem_adr_o,

    output logic                                        line_ready_o,
    output icache_pkg::line_t                           refill_line_o
);

    enum logic [1:0] {IDLE, STROBE, WAIT_ACK} state_q, state_d;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:     if (fetch_start_i) state_d = STROBE;
            STROBE: begin
                if (mem_ack_i) begin
                    state_d = IDLE;        // ack together with the strobe
                end else if (!mem_stall_i) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: if (mem_ack_i) state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    // line address and returned line
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && fetch_start_i) begin
            mem_adr_o <= {fetch_addr_i.fields.tag, fetch_addr_i.fields.index};
        end
        if (line_ready_o) begin
            refill_line_o <= mem_dat_i;
        end
    end

    assign mem_cyc_o    = (state_q != IDLE);    // held until ack
    assign mem_stb_o    = (state_q == STROBE);  // held through stall
    assign line_ready_o = mem_cyc_o & mem_ack_i;

endmodule

/* src/icache_settings.svh */
// Size settings for the instruction cache.
// Include wherever the address, word or line widths are needed.

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// word address and word widths
`define ICACHE_ADDR_W    16
`define ICACHE_DATA_W    32

// 4 words per line, 8 sets
`define ICACHE_OFFSET_W  2
`define ICACHE_SETS_LOG2 3

// derived widths
`define ICACHE_LINE_W ((1 << `ICACHE_OFFSET_W) * `ICACHE_DATA_W)
`define ICACHE_TAG_W  (`ICACHE_ADDR_W - `ICACHE_SETS_LOG2 - `ICACHE_OFFSET_W)

`endif

/* src/icache_top.sv */
// Top level of the 2-way set-associative instruction cache.
// CPU fetch port is a pipelined Wishbone slave, memory port a master
// reading whole 128-bit lines.

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,

    // CPU fetch port
    input  logic                                        cpu_cyc_i,
    input  logic                                        cpu_stb_i,
    input  logic [`ICACHE_ADDR_W-1:0]                   cpu_adr_i,
    output logic                                        cpu_stall_o,
    output logic                                        cpu_ack_o,
    output logic [`ICACHE_DATA_W-1:0]                   cpu_dat_o,

    // memory port
    output logic                                        mem_cyc_o,
    output logic                                        mem_stb_o,
    output logic [`ICACHE_ADDR_W-`ICACHE_OFFSET_W-1:0]  mem_adr_o,
    input  logic                                        mem_stall_i,
    input  logic                                        mem_ack_i,
    input  logic [`ICACHE_LINE_W-1:0]                   mem_dat_i
);

    import icache_pkg::*;

    logic                              req_valid;
    fetch_addr_u                       req_addr;
    logic [1:0]                        way_valid;
    logic [1:0][`ICACHE_TAG_W-1:0]     way_tag;
    line_t [1:0]                       way_line;
    logic [1:0]                        valid_we;
    logic [`ICACHE_SETS_LOG2-1:0]      wr_index;
    logic [`ICACHE_TAG_W-1:0]          wr_tag;
    line_t                             wr_line;
    logic                              fetch_start;
    logic                              line_ready;
    line_t                             refill_line;

    icache_lookup lookup_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cpu_cyc_i   (cpu_cyc_i),
        .cpu_stb_i   (cpu_stb_i),
        .cpu_adr_i   (cpu_adr_i),
        .stall_i     (cpu_stall_o),  // same stall the CPU sees
        .valid_we_i  (valid_we),
        .wr_index_i  (wr_index),
        .wr_tag_i    (wr_tag),
        .wr_line_i   (wr_line),
        .req_valid_o (req_valid),
        .req_addr_o  (req_addr),
        .way_valid_o (way_valid),
        .way_tag_o   (way_tag),
        .way_line_o  (way_line)
    );

    icache_hit_check hit_check_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (req_valid),
        .req_addr_i    (req_addr),
        .way_valid_i   (way_valid),
        .way_tag_i     (way_tag),
        .way_line_i    (way_line),
        .line_ready_i  (line_ready),
        .refill_line_i (refill_line),
        .cpu_ack_o     (cpu_ack_o),
        .cpu_dat_o     (cpu_dat_o),
        .cpu_stall_o   (cpu_stall_o),
        .fetch_start_o (fetch_start),
        .valid_we_o    (valid_we),
        .wr_index_o    (wr_index),
        .wr_tag_o      (wr_tag),
        .wr_line_o     (wr_line)
    );

    icache_refill refill_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .fetch_start_i (fetch_start),
        .fetch_addr_i  (req_addr),
        .mem_stall_i   (mem_stall_i),
        .mem_ack_i     (mem_ack_i),
        .mem_dat_i     (mem_dat_i),
        .mem_cyc_o     (mem_cyc_o),
        .mem_stb_o     (mem_stb_o),
        .mem_adr_o     (mem_adr_o),
        .line_ready_o  (line_ready),
        .refill_line_o (refill_line)
    );

endmodule

/* src/sdp_mem.sv */
// Simple dual-port RAM with one write port and one registered read port.
// Used for the tag and data stores of each cache way.

`timescale 1ns/1ps

module sdp_mem #(
    parameter int unsigned DW = 32,  // word width
    parameter int unsigned AW = 3    // address width
) (
    input  logic          clk_i,

    input  logic          rd_en_i,
    input  logic [AW-1:0] rd_addr_i,
    output logic [DW-1:0] rd_data_o,

    input  logic          wr_en_i,
    input  logic [AW-1:0] wr_addr_i,
    input  logic [DW-1:0] wr_data_i
);

    logic [DW-1:0] mem [2**AW];

    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = '0;  // clean contents at start
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];  // read holds when not enabled
        end
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

/* tests/icache_assert.sv */
// Protocol assertions for the cache ports.
// Attached to icache_top by the bind at the end of this file.

`timescale 1ns/1ps

module icache_assert (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic cpu_cyc_i,
    input  logic cpu_stb_i,
    input  logic cpu_stall_i,
    input  logic cpu_ack_i,
    input  logic mem_cyc_i,
    input  logic mem_stb_i,
    input  logic mem_stall_i,
    input  logic mem_ack_i
);

    logic       accept;
    logic [3:0] pending_q;  // accepted requests not yet acked

    assign accept = cpu_cyc_i & cpu_stb_i & ~cpu_stall_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_q + 4'(accept) - 4'(cpu_ack_i);
        end
    end

    ack_has_request: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_ack_i |-> (pending_q != 0))
        else $error("cpu ack without an open request");

    mem_stb_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_stb_i && mem_stall_i) |=> mem_stb_i)
        else $error("memory strobe dropped while stalled");

    mem_cyc_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_cyc_i && !mem_ack_i) |=> mem_cyc_i)
        else $error("memory cycle dropped before ack");

    // the CPU port stays closed for the whole line read
    no_accept_during_refill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_cyc_i |-> !accept)
        else $error("cpu request accepted during a line read");

endmodule

bind icache_top icache_assert icache_assert_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .cpu_cyc_i   (cpu_cyc_i),
    .cpu_stb_i   (cpu_stb_i),
    .cpu_stall_i (cpu_stall_o),
    .cpu_ack_i   (cpu_ack_o),
    .mem_cyc_i   (mem_cyc_o),
    .mem_stb_i   (mem_stb_o),
    .mem_stall_i (mem_stall_i),
    .mem_ack_i   (mem_ack_i)
);

/* tests/icache_tb.sv */
// Instruction cache testbench. Random fetches are checked against a reference
// model of tags, valid and age bits, with a random-latency line memory.
// Inputs change and outputs are sampled on the falling clock edge.

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;

    localparam int ADDR_W        = `ICACHE_ADDR_W;
    localparam int DATA_W        = `ICACHE_DATA_W;
    localparam int OFF_W         = `ICACHE_OFFSET_W;
    localparam int SETS_LOG2     = `ICACHE_SETS_LOG2;
    localparam int TAG_W         = `ICACHE_TAG_W;
    localparam int LINE_W        = `ICACHE_LINE_W;
    localparam int NUM_SETS      = 1 << SETS_LOG2;
    localparam int LINE_ADR_W    = ADDR_W - OFF_W;
    localparam int NUM_RANDOM    = 400;
    localparam int MAX_MEM_STALL = 3;
    localparam int MAX_MEM_LAT   = 3;
    localparam int MAX_MISS_LAT  = MAX_MEM_STALL + MAX_MEM_LAT + 4;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              miss;
        int                dec_cycle;  // cycle of the hit decision
    } exp_t;

    logic                  clk;
    logic                  rstn;
    logic                  cpu_cyc;
    logic                  cpu_stb;
    logic [ADDR_W-1:0]     cpu_adr;
    logic                  cpu_stall;
    logic                  cpu_ack;
    logic [DATA_W-1:0]     cpu_dat;
    logic                  mem_cyc;
    logic                  mem_stb;
    logic [LINE_ADR_W-1:0] mem_adr;
    logic                  mem_stall;
    logic                  mem_ack;
    logic [LINE_W-1:0]     mem_dat;

    int   seed = 45;
    int   cycle = 0;
    int   popped = 0;
    int   mem_phase = 0;      // 0 idle, 1 stalling the strobe, 2 ack latency
    int   mem_left = 0;
    int   strobes_taken = 0;
    int   model_misses = 0;
    int   front_strobes = 0;  // strobes seen for the oldest open request
    int   checks = 0;
    int   value_errors = 0;
    int   other_errors = 0;
    logic drv_stb = 1'b0;
    logic stall_seen = 1'b0;
    logic after_refill = 1'b0;

    logic [TAG_W-1:0]  model_tag   [2][NUM_SETS];
    logic              model_valid [2][NUM_SETS];
    logic              model_age   [NUM_SETS];
    exp_t              exp_q [$];
    logic [ADDR_W-1:0] stim_q [$];

    tb_clock_gen clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    icache_top icache_top_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .cpu_cyc_i   (cpu_cyc),
        .cpu_stb_i   (cpu_stb),
        .cpu_adr_i   (cpu_adr),
        .cpu_stall_o (cpu_stall),
        .cpu_ack_o   (cpu_ack),
        .cpu_dat_o   (cpu_dat),
        .mem_cyc_o   (mem_cyc),
        .mem_stb_o   (mem_stb),
        .mem_adr_o   (mem_adr),
        .mem_stall_i (mem_stall),
        .mem_ack_i   (mem_ack),
        .mem_dat_i   (mem_dat)
    );

    // helpers
    // **************************************************
    function automatic int random_below(input int n);
        random_below = ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // memory word k of a line is a fixed hash of line address and k
    function automatic logic [DATA_W-1:0] line_word(input logic [LINE_ADR_W-1:0] line_adr,
                                                    input logic [OFF_W-1:0] k);
        line_word = (32'({line_adr, k}) * 32'h9E37_79B1) ^ 32'h3C5A_0F69;
    endfunction

    function automatic logic [LINE_W-1:0] make_line(input logic [LINE_ADR_W-1:0] line_adr);
        for (int k = 0; k < (1 << OFF_W); k++) begin
            make_line[k*DATA_W +: DATA_W] = line_word(line_adr, OFF_W'(k));
        end
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int off);
        make_addr = ADDR_W'((tag << (OFF_W + SETS_LOG2)) | (set << OFF_W) | off);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            value_errors++;
            $display("error %s at cycle %0d: expected %0h, actual %0h",
                     name, cycle, expected, actual);
        end
    endtask

    // reference model update in request order
    task automatic record_request(input logic [ADDR_W-1:0] addr);
        logic [TAG_W-1:0]     tag;
        logic [SETS_LOG2-1:0] set;
        logic                 hit;
        logic                 victim;
        tag = addr[ADDR_W-1:OFF_W+SETS_LOG2];
        set = addr[OFF_W+SETS_LOG2-1:OFF_W];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][set] && model_tag[w][set] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            victim = model_age[set];          // age bit names the way to replace
            model_tag[victim][set]   = tag;
            model_valid[victim][set] = 1'b1;
            model_age[set]           = ~victim;
            model_misses++;
        end
        exp_q.push_back('{addr: addr, miss: !hit, dec_cycle: cycle});
    endtask

    task automatic check_cpu_side();
        exp_t e;
        if (after_refill) begin
            check_value("stall_after_refill", 32'd0, 32'(cpu_stall));
            after_refill = 1'b0;
        end
        if (exp_q.size() > 0 && exp_q[0].miss) begin
            check_value("stall_during_miss", 32'd1, 32'(cpu_stall));
        end
        if (cpu_ack) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("ack seen at cycle %0d with no request outstanding", cycle);
            end else begin
                e = exp_q.pop_front();
                check_value("data", line_word(e.addr[ADDR_W-1:OFF_W], e.addr[OFF_W-1:0]),
                            cpu_dat);
                check_value("strobes_for_request", 32'(e.miss), 32'(front_strobes));
                if (!e.miss) begin
                    check_value("hit_ack_cycle", 32'(e.dec_cycle), 32'(cycle));
                end
                front_strobes = 0;
                after_refill  = e.miss;
            end
        end
    endtask

    task automatic note_strobe();
        strobes_taken++;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("memory strobe taken at cycle %0d with no request outstanding", cycle);
        end else begin
            check_value("strobe_on_miss", 32'd1, 32'(exp_q[0].miss));
            check_value("line_address", 32'(exp_q[0].addr[ADDR_W-1:OFF_W]), 32'(mem_adr));
            front_strobes++;
        end
    endtask

    // line memory with a random stall on the strobe and a random ack latency
    task automatic step_memory();
        mem_ack = 1'b0;
        if (mem_phase != 0 || !mem_stb) begin
            check_value("mem_cyc", 32'(mem_phase != 0), 32'(mem_cyc));  // open from strobe to ack
        end
        if (mem_phase == 0) begin
            mem_stall = 1'(random_below(2));  // ignored while no strobe is up
            if (mem_stb) begin
                mem_left  = random_below(MAX_MEM_STALL + 1);
                mem_phase = 1;
            end
        end
        if (mem_phase == 1) begin
            check_value("mem_stb_held", 32'd1, 32'(mem_stb));
            if (mem_left > 0) begin
                mem_stall = 1'b1;
                mem_left--;
            end else begin
                mem_stall = 1'b0;  // strobe taken on the coming edge
                note_strobe();
                mem_left  = random_below(MAX_MEM_LAT + 1);
                mem_phase = 2;
            end
        end else if (mem_phase == 2) begin
            if (mem_left > 0) begin
                mem_left--;
            end else begin
                mem_ack   = 1'b1;
                mem_dat   = make_line(mem_adr);
                mem_phase = 0;
            end
        end
    endtask

    // main sequence
    // **************************************************
    initial begin : run_test
        int   n_directed;
        int   cycle_limit;
        logic gap;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_adr   = '0;
        mem_stall = 1'b0;
        mem_ack   = 1'b0;
        mem_dat   = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_age[s]      = 1'b0;
        end

        // a third tag in set 1 evicts one way, then the kept and evicted tags return
        stim_q.push_back(make_addr(1, 1, 0));
        stim_q.push_back(make_addr(2, 1, 1));
        stim_q.push_back(make_addr(3, 1, 2));
        stim_q.push_back(make_addr(2, 1, 3));
        stim_q.push_back(make_addr(1, 1, 0));
        stim_q.push_back(make_addr(3, 1, 1));
        for (int i = 0; i < 8; i++) begin
            stim_q.push_back(make_addr(0, 2, i % 4));  // back-to-back hits after one miss
        end
        n_directed = stim_q.size();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            stim_q.push_back(make_addr(random_below(4), random_below(NUM_SETS),
                                       random_below(4)));
        end
        cycle_limit = stim_q.size() * (MAX_MISS_LAT + 10);

        @(posedge rstn);
        cpu_cyc = 1'b1;
        while ((stim_q.size() > 0 || drv_stb || exp_q.size() > 0 || mem_phase != 0
                || after_refill) && cycle < cycle_limit) begin
            @(negedge clk);
            cycle++;
            if (drv_stb && !stall_seen) begin
                record_request(cpu_adr);  // accepted on the edge just passed
                drv_stb = 1'b0;
            end
            stall_seen = cpu_stall;
            check_cpu_side();
            step_memory();
            if (!drv_stb && stim_q.size() > 0) begin
                gap = (popped >= n_directed) && (random_below(4) == 0);
                if (!gap) begin
                    cpu_adr = stim_q.pop_front();
                    drv_stb = 1'b1;
                    popped++;
                end
            end
            cpu_stb = drv_stb;  // held while stalled
        end
        cpu_cyc = 1'b0;

        if (stim_q.size() > 0 || drv_stb || exp_q.size() > 0 || mem_phase != 0) begin
            other_errors++;
            $display("run stopped at the cycle limit of %0d with %0d requests open",
                     cycle_limit, exp_q.size() + stim_q.size());
        end
        check_value("strobes_vs_misses", 32'(model_misses), 32'(strobes_taken));

        $display("accesses: %0d, misses: %0d, checks: %0d, value errors: %0d, other errors: %0d",
                 popped, model_misses, checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clock_gen.sv */
// Clock and reset source for the cache testbench.
// 10 ns clock; reset held low over the first 10 rising edges.

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    initial begin
        repeat (10) @(negedge clk_o);
        rstn_o = 1'b1;  // released on a falling edge
    end

endmodule
